// ==== flist.f ====
hw/mem_chk_pkg.sv
hw/port_protocol_checker.sv
hw/read_data_checker.sv
hw/map_table_checker.sv
hw/error_collector.sv
hw/mem_checker_top.sv
testbench/tb_mem_checker.sv

// ==== hw/error_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module error_collector
  import mem_chk_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic [NUM_PORTS-1:0] rw_err,
  input  wire logic [NUM_PORTS-1:0] range_err,
  input  wire logic [NUM_PORTS-1:0] missing_err,
  input  wire logic [NUM_PORTS-1:0] data_err,
  input  wire logic [NUM_PORTS-1:0] map_err,
  output chk_err_t                  err_status,
  output err_code_e                 first_err,
  output logic                      err_any
);

  chk_err_t  pulse;
  err_code_e pulse_code;

  assign pulse.rw_conflict = |rw_err;
  assign pulse.addr_range  = |range_err;
  assign pulse.rd_missing  = |missing_err;
  assign pulse.rd_data     = |data_err;
  assign pulse.map_data    = |map_err;

  // Simultaneous errors resolve to the lowest code
  always_comb begin
    pulse_code = ERR_NONE;
    if (pulse.rw_conflict) begin
      pulse_code = ERR_RW_CONFLICT;
    end else if (pulse.addr_range) begin
      pulse_code = ERR_ADDR_RANGE;
    end else if (pulse.rd_missing) begin
      pulse_code = ERR_RD_MISSING;
    end else if (pulse.rd_data) begin
      pulse_code = ERR_RD_DATA;
    end else if (pulse.map_data) begin
      pulse_code = ERR_MAP_DATA;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      err_status <= '0;
      first_err  <= ERR_NONE;
    end else begin
      err_status <= err_status | pulse;
      if ((first_err == ERR_NONE) && (pulse_code != ERR_NONE)) begin
        first_err <= pulse_code;
      end
    end
  end

  assign err_any = |err_status;

endmodule

`default_nettype wire

// ==== hw/map_table_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module map_table_checker
  import mem_chk_pkg::*;
#(
  parameter int BITADDR    = 13,
  parameter int NUM_VBNK   = 8,
  parameter int BITVBNK    = 3,
  parameter int NUM_VROW   = 1024,
  parameter int BITVROW    = 10,
  parameter int SRAM_DELAY = 2
) (
  input  wire logic                                 clk,
  input  wire logic                                 rst,
  input  wire logic                                 map_write,
  input  wire logic [BITVROW-1:0]                   map_waddr,
  input  wire logic [BITVBNK:0]                     map_din,
  input  wire logic [NUM_PORTS-1:0]                 map_read,
  input  wire logic [NUM_PORTS*BITVROW-1:0]         map_raddr,
  input  wire logic [NUM_PORTS*(BITVBNK+1)-1:0]     map_dout,
  input  wire logic [BITADDR-1:0]                   select_addr,
  output logic      [NUM_PORTS-1:0]                 map_err
);

  localparam int ENTRY_W = BITVBNK + 1;

  typedef struct packed {
    logic               pend;
    logic [ENTRY_W-1:0] exp_entry;
  } map_track_t;

  logic [BITADDR-1:0]   row_full;
  logic [BITVROW-1:0]   watch_row;
  logic                 watch_ok;
  logic [ENTRY_W-1:0]   map_shadow;
  logic [NUM_PORTS-1:0] err_now;

  // Flat address splits into bank = addr mod NUM_VBNK, row = addr div NUM_VBNK
  assign row_full  = select_addr / BITADDR'(NUM_VBNK);
  assign watch_row = row_full[BITVROW-1:0];

  // A watch address past the last row has no map entry to follow
  assign watch_ok = (row_full < NUM_VROW);

  always_ff @(posedge clk) begin
    if (rst) begin
      map_shadow <= '0;
    end else if (watch_ok && map_write && (map_waddr == watch_row)) begin
      map_shadow <= map_din;
    end
  end

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    logic [BITVROW-1:0] port_raddr;
    logic [ENTRY_W-1:0] port_dout;
    logic               rd_hit;
    map_track_t         pipe [SRAM_DELAY];

    assign port_raddr = map_raddr[p*BITVROW +: BITVROW];
    assign port_dout  = map_dout[p*ENTRY_W +: ENTRY_W];
    assign rd_hit     = watch_ok && map_read[p] && (port_raddr == watch_row);

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int k = 0; k < SRAM_DELAY; k++) begin
          pipe[k] <= '0;
        end
      end else begin
        pipe[0] <= '{pend: rd_hit, exp_entry: map_shadow};
        for (int k = 1; k < SRAM_DELAY; k++) begin
          pipe[k] <= pipe[k-1];
        end
      end
    end

    // Valid bit and bank number must both match
    assign err_now[p] = pipe[SRAM_DELAY-1].pend &&
                        (port_dout != pipe[SRAM_DELAY-1].exp_entry);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      map_err <= '0;
    end else begin
      map_err <= err_now;
    end
  end

endmodule

`default_nettype wire

// ==== hw/mem_checker_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_checker_top
  import mem_chk_pkg::*;
#(
  parameter int WIDTH      = 32,
  parameter int BITWDTH    = 5,
  parameter int NUM_ADDR   = 8192,
  parameter int BITADDR    = 13,
  parameter int NUM_VBNK   = 8,
  parameter int BITVBNK    = 3,
  parameter int NUM_VROW   = 1024,
  parameter int BITVROW    = 10,
  parameter int READ_DELAY = 2,
  parameter int SRAM_DELAY = 2
) (
  input  wire logic                                 clk,
  input  wire logic                                 rst,
  input  wire logic [NUM_PORTS-1:0]                 read,
  input  wire logic [NUM_PORTS-1:0]                 write,
  input  wire logic [NUM_PORTS*BITADDR-1:0]         addr,
  input  wire logic [NUM_PORTS*WIDTH-1:0]           din,
  input  wire logic [NUM_PORTS-1:0]                 rd_vld,
  input  wire logic [NUM_PORTS*WIDTH-1:0]           rd_dout,
  input  wire logic                                 map_write,
  input  wire logic [BITVROW-1:0]                   map_waddr,
  input  wire logic [BITVBNK:0]                     map_din,
  input  wire logic [NUM_PORTS-1:0]                 map_read,
  input  wire logic [NUM_PORTS*BITVROW-1:0]         map_raddr,
  input  wire logic [NUM_PORTS*(BITVBNK+1)-1:0]     map_dout,
  input  wire logic [BITADDR-1:0]                   select_addr,
  input  wire logic [BITWDTH-1:0]                   select_bit,
  output chk_err_t                                  err_status,
  output err_code_e                                 first_err,
  output logic                                      err_any
);

  logic [NUM_PORTS-1:0] rw_err;
  logic [NUM_PORTS-1:0] range_err;
  logic [NUM_PORTS-1:0] missing_err;
  logic [NUM_PORTS-1:0] data_err;
  logic [NUM_PORTS-1:0] map_err;

  port_protocol_checker #(
    .NUM_ADDR (NUM_ADDR),
    .BITADDR  (BITADDR)
  ) u_port_chk (
    .clk       (clk),
    .rst       (rst),
    .read      (read),
    .write     (write),
    .addr      (addr),
    .rw_err    (rw_err),
    .range_err (range_err)
  );

  read_data_checker #(
    .WIDTH      (WIDTH),
    .BITWDTH    (BITWDTH),
    .BITADDR    (BITADDR),
    .READ_DELAY (READ_DELAY)
  ) u_read_chk (
    .clk         (clk),
    .rst         (rst),
    .read        (read),
    .write       (write),
    .addr        (addr),
    .din         (din),
    .rd_vld      (rd_vld),
    .rd_dout     (rd_dout),
    .select_addr (select_addr),
    .select_bit  (select_bit),
    .missing_err (missing_err),
    .data_err    (data_err)
  );

  map_table_checker #(
    .BITADDR    (BITADDR),
    .NUM_VBNK   (NUM_VBNK),
    .BITVBNK    (BITVBNK),
    .NUM_VROW   (NUM_VROW),
    .BITVROW    (BITVROW),
    .SRAM_DELAY (SRAM_DELAY)
  ) u_map_chk (
    .clk         (clk),
    .rst         (rst),
    .map_write   (map_write),
    .map_waddr   (map_waddr),
    .map_din     (map_din),
    .map_read    (map_read),
    .map_raddr   (map_raddr),
    .map_dout    (map_dout),
    .select_addr (select_addr),
    .map_err     (map_err)
  );

  error_collector u_err_col (
    .clk         (clk),
    .rst         (rst),
    .rw_err      (rw_err),
    .range_err   (range_err),
    .missing_err (missing_err),
    .data_err    (data_err),
    .map_err     (map_err),
    .err_status  (err_status),
    .first_err   (first_err),
    .err_any     (err_any)
  );

endmodule

`default_nettype wire

// ==== hw/mem_chk_pkg.sv ====
`default_nettype none

package mem_chk_pkg;

  // User ports of the memory under check
  localparam int NUM_PORTS = 2;

  // One sticky flag per error class
  typedef struct packed {
    logic rw_conflict;
    logic addr_range;
    logic rd_missing;
    logic rd_data;
    logic map_data;
  } chk_err_t;

  // Lower value wins when several classes fire in the same cycle
  typedef enum logic [2:0] {
    ERR_NONE        = 3'd0,
    ERR_RW_CONFLICT = 3'd1,
    ERR_ADDR_RANGE  = 3'd2,
    ERR_RD_MISSING  = 3'd3,
    ERR_RD_DATA     = 3'd4,
    ERR_MAP_DATA    = 3'd5
  } err_code_e;

endpackage

`default_nettype wire

// ==== hw/port_protocol_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_protocol_checker
  import mem_chk_pkg::*;
#(
  parameter int NUM_ADDR = 8192,
  parameter int BITADDR  = 13
) (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire logic [NUM_PORTS-1:0]           read,
  input  wire logic [NUM_PORTS-1:0]           write,
  input  wire logic [NUM_PORTS*BITADDR-1:0]   addr,
  output logic      [NUM_PORTS-1:0]           rw_err,
  output logic      [NUM_PORTS-1:0]           range_err
);

  logic [NUM_PORTS-1:0] rw_now;
  logic [NUM_PORTS-1:0] range_now;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    logic [BITADDR-1:0] port_addr;

    assign port_addr = addr[p*BITADDR +: BITADDR];

    // A single port may either read or write in one cycle, never both
    assign rw_now[p] = read[p] && write[p];

    // Only active accesses carry a meaningful address
    assign range_now[p] = (read[p] || write[p]) && (port_addr >= NUM_ADDR);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rw_err    <= '0;
      range_err <= '0;
    end else begin
      rw_err    <= rw_now;
      range_err <= range_now;
    end
  end

endmodule

`default_nettype wire

// ==== hw/read_data_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_data_checker
  import mem_chk_pkg::*;
#(
  parameter int WIDTH      = 32,
  parameter int BITWDTH    = 5,
  parameter int BITADDR    = 13,
  parameter int READ_DELAY = 2
) (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire logic [NUM_PORTS-1:0]           read,
  input  wire logic [NUM_PORTS-1:0]           write,
  input  wire logic [NUM_PORTS*BITADDR-1:0]   addr,
  input  wire logic [NUM_PORTS*WIDTH-1:0]     din,
  input  wire logic [NUM_PORTS-1:0]           rd_vld,
  input  wire logic [NUM_PORTS*WIDTH-1:0]     rd_dout,
  input  wire logic [BITADDR-1:0]             select_addr,
  input  wire logic [BITWDTH-1:0]             select_bit,
  output logic      [NUM_PORTS-1:0]           missing_err,
  output logic      [NUM_PORTS-1:0]           data_err
);

  // State of one outstanding read of the watched address
  typedef struct packed {
    logic pend;
    logic exp_bit;
    logic exp_vld;
  } rd_track_t;

  logic [NUM_PORTS-1:0] wr_hit;
  logic [NUM_PORTS-1:0] rd_hit;
  logic [NUM_PORTS-1:0] wr_bit;
  logic [NUM_PORTS-1:0] missing_now;
  logic [NUM_PORTS-1:0] data_now;

  logic shadow_bit;
  logic shadow_vld;
  logic shadow_nxt;
  logic shadow_upd;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    logic [BITADDR-1:0] port_addr;
    logic [WIDTH-1:0]   port_din;
    logic [WIDTH-1:0]   port_dout;
    rd_track_t          pipe [READ_DELAY];

    assign port_addr = addr[p*BITADDR +: BITADDR];
    assign port_din  = din[p*WIDTH +: WIDTH];
    assign port_dout = rd_dout[p*WIDTH +: WIDTH];

    assign wr_hit[p] = write[p] && (port_addr == select_addr);
    assign rd_hit[p] = read[p] && (port_addr == select_addr);
    assign wr_bit[p] = port_din[select_bit];

    // The shadow is sampled before this edge's write lands, so a read
    // alongside a write of the same address expects the old bit
    always_ff @(posedge clk) begin
      if (rst) begin
        for (int k = 0; k < READ_DELAY; k++) begin
          pipe[k] <= '0;
        end
      end else begin
        pipe[0] <= '{pend: rd_hit[p], exp_bit: shadow_bit, exp_vld: shadow_vld};
        for (int k = 1; k < READ_DELAY; k++) begin
          pipe[k] <= pipe[k-1];
        end
      end
    end

    assign missing_now[p] = pipe[READ_DELAY-1].pend && !rd_vld[p];
    assign data_now[p]    = pipe[READ_DELAY-1].pend && rd_vld[p] &&
                            pipe[READ_DELAY-1].exp_vld &&
                            (port_dout[select_bit] != pipe[READ_DELAY-1].exp_bit);
  end

  // Higher port index overrides, so port 1 wins a double write
  always_comb begin
    shadow_nxt = shadow_bit;
    shadow_upd = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (wr_hit[p]) begin
        shadow_nxt = wr_bit[p];
        shadow_upd = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      shadow_vld <= 1'b0;
    end else if (shadow_upd) begin
      shadow_vld <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    shadow_bit <= shadow_nxt;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      missing_err <= '0;
      data_err    <= '0;
    end else begin
      missing_err <= missing_now;
      data_err    <= data_now;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/mem_checker_testdata.txt ====
// rd wr a0 a1 d0 d1 vl o0 o1 mw wa md mr r0 r1 m0 m1 st fe
// One cycle per line: user ports, read response, map ports, then expected err_status, first_err
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 01 14 00 20 00 00 00 00 00 00 00 00 00 00 00 00 00 00
02 00 00 14 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 02 00 20 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 03 14 14 20 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 02 14 14 00 20 00 00 00 00 00 00 00 00 00 00 00 00 00
02 00 00 14 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 01 DF 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 02 00 20 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
02 00 00 14 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 02 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 02 04
01 00 14 00 00 00 00 00 00 00 00 00 00 00 00 00 00 02 04
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 02 04
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 02 04
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 06 04
00 00 00 00 00 00 00 00 00 01 03 0A 00 00 00 00 00 06 04
00 00 00 00 00 00 00 00 00 00 00 00 03 03 03 00 00 06 04
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 06 04
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0A 0A 06 04
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 06 04
00 00 00 00 00 00 00 00 00 00 00 00 01 03 00 00 00 06 04
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 06 04
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 02 00 06 04
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 07 04
01 01 05 00 00 00 00 00 00 00 00 00 00 00 00 00 00 07 04
00 02 00 32 00 00 00 00 00 00 00 00 00 00 00 00 00 17 04
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1F 04
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1F 04

// ==== testbench/tb_mem_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_checker
  import mem_chk_pkg::*;
();

  localparam int WIDTH      = 8;
  localparam int BITWDTH    = 3;
  localparam int NUM_ADDR   = 48;
  localparam int BITADDR    = 6;
  localparam int NUM_VBNK   = 6;
  localparam int BITVBNK    = 3;
  localparam int NUM_VROW   = 8;
  localparam int BITVROW    = 3;
  localparam int READ_DELAY = 2;
  localparam int SRAM_DELAY = 2;

  // Watched address 20 sits in bank 2, row 3
  localparam logic [BITADDR-1:0] WATCH_ADDR = 6'd20;
  localparam logic [BITWDTH-1:0] WATCH_BIT  = 3'd5;

  localparam int NUM_FIELDS   = 19;
  localparam int NUM_VEC      = 34;
  localparam int RESET_CYCLES = 4;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_VEC + 20;

  logic                                 clk;
  logic                                 rst;
  logic [NUM_PORTS-1:0]                 read;
  logic [NUM_PORTS-1:0]                 write;
  logic [NUM_PORTS*BITADDR-1:0]         addr;
  logic [NUM_PORTS*WIDTH-1:0]           din;
  logic [NUM_PORTS-1:0]                 rd_vld;
  logic [NUM_PORTS*WIDTH-1:0]           rd_dout;
  logic                                 map_write;
  logic [BITVROW-1:0]                   map_waddr;
  logic [BITVBNK:0]                     map_din;
  logic [NUM_PORTS-1:0]                 map_read;
  logic [NUM_PORTS*BITVROW-1:0]         map_raddr;
  logic [NUM_PORTS*(BITVBNK+1)-1:0]     map_dout;
  logic [BITADDR-1:0]                   select_addr;
  logic [BITWDTH-1:0]                   select_bit;
  chk_err_t                             err_status;
  err_code_e                            first_err;
  logic                                 err_any;

  logic [15:0] vec_mem [NUM_FIELDS*NUM_VEC];
  int          cycle_cnt = 0;

  mem_checker_top #(
    .WIDTH      (WIDTH),
    .BITWDTH    (BITWDTH),
    .NUM_ADDR   (NUM_ADDR),
    .BITADDR    (BITADDR),
    .NUM_VBNK   (NUM_VBNK),
    .BITVBNK    (BITVBNK),
    .NUM_VROW   (NUM_VROW),
    .BITVROW    (BITVROW),
    .READ_DELAY (READ_DELAY),
    .SRAM_DELAY (SRAM_DELAY)
  ) dut0 (
    .clk         (clk),
    .rst         (rst),
    .read        (read),
    .write       (write),
    .addr        (addr),
    .din         (din),
    .rd_vld      (rd_vld),
    .rd_dout     (rd_dout),
    .map_write   (map_write),
    .map_waddr   (map_waddr),
    .map_din     (map_din),
    .map_read    (map_read),
    .map_raddr   (map_raddr),
    .map_dout    (map_dout),
    .select_addr (select_addr),
    .select_bit  (select_bit),
    .err_status  (err_status),
    .first_err   (first_err),
    .err_any     (err_any)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the test sequence did not complete", cycle_cnt);
      $display("Checks failed");
      $fatal(1, "Simulation stopped by timeout");
    end
  end

  task automatic check_value(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("Checks failed");
      $fatal(1, "Stopped at first error");
    end
  endtask

  // Port 1 sits in the upper half of every packed per-port vector
  task automatic apply_vector(input int idx);
    int b;
    b = idx * NUM_FIELDS;
    read      = vec_mem[b][NUM_PORTS-1:0];
    write     = vec_mem[b+1][NUM_PORTS-1:0];
    addr      = {vec_mem[b+3][BITADDR-1:0], vec_mem[b+2][BITADDR-1:0]};
    din       = {vec_mem[b+5][WIDTH-1:0], vec_mem[b+4][WIDTH-1:0]};
    rd_vld    = vec_mem[b+6][NUM_PORTS-1:0];
    rd_dout   = {vec_mem[b+8][WIDTH-1:0], vec_mem[b+7][WIDTH-1:0]};
    map_write = vec_mem[b+9][0];
    map_waddr = vec_mem[b+10][BITVROW-1:0];
    map_din   = vec_mem[b+11][BITVBNK:0];
    map_read  = vec_mem[b+12][NUM_PORTS-1:0];
    map_raddr = {vec_mem[b+14][BITVROW-1:0], vec_mem[b+13][BITVROW-1:0]};
    map_dout  = {vec_mem[b+16][BITVBNK:0], vec_mem[b+15][BITVBNK:0]};
  endtask

  task automatic check_vector(input int idx);
    int b;
    b = idx * NUM_FIELDS;
    check_value("err_status", {3'b000, err_status}, vec_mem[b+17][7:0]);
    check_value("first_err", {5'b00000, first_err}, vec_mem[b+18][7:0]);
    // err_any is the OR of every sticky flag
    check_value("err_any", {7'd0, err_any}, {7'd0, |vec_mem[b+17][4:0]});
  endtask

  initial begin
    rst         = 1'b1;
    read        = '0;
    write       = '0;
    addr        = '0;
    din         = '0;
    rd_vld      = '0;
    rd_dout     = '0;
    map_write   = 1'b0;
    map_waddr   = '0;
    map_din     = '0;
    map_read    = '0;
    map_raddr   = '0;
    map_dout    = '0;
    select_addr = WATCH_ADDR;
    select_bit  = WATCH_BIT;

    $readmemh("testbench/mem_checker_testdata.txt", vec_mem);
    if ($isunknown(vec_mem[NUM_FIELDS*NUM_VEC-1])) begin
      $display("The test data file is missing or holds fewer vectors than expected");
      $display("Checks failed");
      $fatal(1, "Cannot run without test data");
    end

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int v = 0; v < NUM_VEC; v++) begin
      apply_vector(v);
      @(negedge clk);
      check_vector(v);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
